/* compile.f */
+incdir+rtl
rtl/cu_pkg.sv
rtl/instr_decoder.sv
rtl/control_sequencer.sv
rtl/control_outputs.sv
rtl/control_unit.sv
tb/tb_control_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f compile.f \
    --top-module tb_control_unit -Mdir obj_dir -o sim_control_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_control_unit > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log
if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb/tb_control_unit.sv */
`include "cu_macros.svh"

module tb_control_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_INSTR = 200;
    localparam int LIMIT   = 16 + N_INSTR * 11 + 50;
    localparam int N_ENT   = 25;
    localparam int N_BEH   = 6;
    localparam int B_RESET = 0;
    localparam int B_LEN   = 1;
    localparam int B_WB    = 2;
    localparam int B_XFER  = 3;
    localparam int B_STORE = 4;
    localparam int B_EXC   = 5;
    localparam int K_ALU   = 0;
    localparam int K_BR    = 1;
    localparam int K_JUMP  = 2;
    localparam int K_JR    = 3;
    localparam int K_LOAD  = 4;
    localparam int K_STORE = 5;
    localparam int K_EXC   = 6;

    logic                   clk;
    logic                   arst_n;
    logic [`CU_OP_W-1:0]    op;
    logic [`CU_OP_W-1:0]    funct;
    logic                   ab_load;
    logic                   ir_load;
    logic                   pc_write;
    logic                   pc_write_cond;
    logic                   reg_write;
    logic                   mem_wr;
    logic                   epc_load;
    logic                   alu_out_load;
    logic                   mdr_load;
    logic                   sel_reg_read;
    logic                   sel_alu_src_a;
    logic [`CU_SRCB_W-1:0]  sel_alu_src_b;
    logic [`CU_BR_W-1:0]    sel_branch_op;
    logic [`CU_SIZE_W-1:0]  ls_size;
    logic [`CU_SIZE_W-1:0]  ss_size;
    logic [`CU_ALU_W-1:0]   sel_alu_op;
    logic [`CU_PCSRC_W-1:0] sel_pc_source;
    logic [`CU_IORD_W-1:0]  sel_iord;
    logic [`CU_DST_W-1:0]   sel_reg_dst;
    logic [`CU_WB_W-1:0]    sel_mem_to_reg;

    // Instruction table, one row per opcode/function pair
    logic [5:0] t_op [N_ENT];
    logic [5:0] t_fn [N_ENT];
    int         t_len [N_ENT];
    int         t_kind [N_ENT];
    int         t_wb [N_ENT];
    logic [2:0] t_dst [N_ENT];
    logic [3:0] t_src [N_ENT];
    logic [1:0] t_arg [N_ENT];  // Branch code or access size
    int         n_ent;

    int         exp_len;
    int         exp_kind;
    int         exp_wb;
    int         exp_cond;
    int         exp_pcw;
    int         exp_mem;
    int         exp_epc;
    logic [2:0] exp_dst;
    logic [3:0] exp_src;
    logic [1:0] exp_arg;

    int gap;
    int n_done;
    int init_writes;
    int n_wb;
    int n_cond;
    int n_pcw;
    int n_mem;
    int n_epc;
    int cycles;
    bit mark_q;
    bit load_pend;
    bit cur_valid;
    int hits [N_BEH];
    int fails [N_BEH];
    string bname [N_BEH] = '{"reset", "length", "write_back", "control", "store", "invalid"};

    wire [8:0] enables = {ab_load, ir_load, pc_write, pc_write_cond, reg_write, mem_wr,
                          epc_load, alu_out_load, mdr_load};
    wire [25:0] selects = {sel_reg_read, sel_alu_src_a, sel_alu_src_b, sel_branch_op, ls_size,
                           ss_size, sel_alu_op, sel_pc_source, sel_iord, sel_reg_dst,
                           sel_mem_to_reg};
    // PC + 4 write of each fetch
    wire mark_now = pc_write && sel_pc_source == `CU_PCSRC_ALU
                    && sel_alu_src_b == `CU_SRCB_FOUR && sel_alu_op == `CU_ALU_ADD;
    wire [6:0] init_sel = {sel_reg_dst, sel_mem_to_reg};
    wire [1:0] size_act = (exp_kind == K_LOAD) ? ls_size : 2'd0;  // Size only matters for loads
    wire [8:0] wb_act = {sel_reg_dst, sel_mem_to_reg, size_act};
    wire [8:0] wb_exp = {exp_dst, exp_src, exp_arg};
    wire [4:0] br_act = {sel_pc_source, sel_branch_op};
    wire [4:0] st_act = {sel_iord, ss_size};

    control_unit dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: %0d of %0d instructions done after %0d cycles",
                     n_done, N_INSTR, cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [2:0] jump_src(input int kind);
        case (kind)
            K_JUMP:  return `CU_PCSRC_JUMP;
            K_EXC:   return `CU_PCSRC_EXC;
            default: return `CU_PCSRC_ALU;  // jr target through the ALU
        endcase
    endfunction

    task automatic report_error(input int b, input int unsigned exp, input int unsigned act);
        $display("ERROR %s: expected %0h actual %0h", bname[b], exp, act);
        fails[b]++;
    endtask

    task automatic add_entry(input logic [5:0] eop, input logic [5:0] efn, input int len,
                             input int kind, input int wb, input logic [2:0] dst,
                             input logic [3:0] src, input logic [1:0] arg);
        t_op[n_ent]   = eop;
        t_fn[n_ent]   = efn;
        t_len[n_ent]  = len;
        t_kind[n_ent] = kind;
        t_wb[n_ent]   = wb;
        t_dst[n_ent]  = dst;
        t_src[n_ent]  = src;
        t_arg[n_ent]  = arg;
        n_ent++;
    endtask

    task automatic fill_table();
        add_entry(`CU_OP_RTYPE, `CU_FN_ADD, 7, K_ALU, 1, `CU_DST_RD, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_RTYPE, `CU_FN_SUB, 7, K_ALU, 1, `CU_DST_RD, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_RTYPE, `CU_FN_AND, 7, K_ALU, 1, `CU_DST_RD, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_RTYPE, `CU_FN_SLT, 6, K_ALU, 1, `CU_DST_RD, `CU_WB_SLT, 2'd0);
        add_entry(`CU_OP_ADDI, 6'h00, 7, K_ALU, 1, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_ADDIU, 6'h00, 7, K_ALU, 1, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_SLTI, 6'h00, 6, K_ALU, 1, `CU_DST_RD, `CU_WB_SLT, 2'd0);
        add_entry(`CU_OP_LUI, 6'h00, 6, K_ALU, 1, `CU_DST_RT, `CU_WB_LUI, 2'd0);
        add_entry(`CU_OP_BEQ, 6'h00, 6, K_BR, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_BR_EQ);
        add_entry(`CU_OP_BNE, 6'h00, 6, K_BR, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_BR_NE);
        add_entry(`CU_OP_BGT, 6'h00, 6, K_BR, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_BR_GT);
        add_entry(`CU_OP_BLE, 6'h00, 6, K_BR, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_BR_LE);
        add_entry(`CU_OP_J, 6'h00, 6, K_JUMP, 0, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_JAL, 6'h00, 8, K_JUMP, 1, `CU_DST_RA, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_RTYPE, `CU_FN_JR, 7, K_JR, 0, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_LW, 6'h00, 10, K_LOAD, 1, `CU_DST_RT, `CU_WB_MDR, `CU_SIZE_WORD);
        add_entry(`CU_OP_LH, 6'h00, 10, K_LOAD, 1, `CU_DST_RT, `CU_WB_MDR, `CU_SIZE_HALF);
        add_entry(`CU_OP_LB, 6'h00, 10, K_LOAD, 1, `CU_DST_RT, `CU_WB_MDR, `CU_SIZE_BYTE);
        add_entry(`CU_OP_SW, 6'h00, 11, K_STORE, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_SIZE_WORD);
        add_entry(`CU_OP_SH, 6'h00, 11, K_STORE, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_SIZE_HALF);
        add_entry(`CU_OP_SB, 6'h00, 11, K_STORE, 0, `CU_DST_RT, `CU_WB_ALUOUT, `CU_SIZE_BYTE);
        add_entry(6'h3f, 6'h00, 10, K_EXC, 0, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(6'h01, 6'h00, 10, K_EXC, 0, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_RTYPE, 6'h3f, 10, K_EXC, 0, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);
        add_entry(`CU_OP_RTYPE, 6'h00, 10, K_EXC, 0, `CU_DST_RT, `CU_WB_ALUOUT, 2'd0);  // sll dropped
    endtask

    task automatic load_instr();
        int i;
        i = $urandom_range(N_ENT - 1);
        op    = t_op[i];
        funct = (t_op[i] == `CU_OP_RTYPE) ? t_fn[i] : 6'($urandom);  // Ignored outside R-type
        exp_len  = t_len[i];
        exp_kind = t_kind[i];
        exp_wb   = t_wb[i];
        exp_dst  = t_dst[i];
        exp_src  = t_src[i];
        exp_arg  = t_arg[i];
        exp_cond = (t_kind[i] == K_BR) ? 1 : 0;
        exp_pcw  = (t_kind[i] == K_JUMP || t_kind[i] == K_JR || t_kind[i] == K_EXC) ? 1 : 0;
        exp_mem  = (t_kind[i] == K_STORE) ? 1 : 0;
        exp_epc  = (t_kind[i] == K_EXC) ? 1 : 0;
        n_wb   = 0;
        n_cond = 0;
        n_pcw  = 0;
        n_mem  = 0;
        n_epc  = 0;
        cur_valid = 1'b1;
    endtask

    task automatic step_cycle();
        gap = mark_q ? 1 : gap + 1;
        if (load_pend) begin
            load_pend = 1'b0;
            load_instr();
        end
        if (reg_write && !cur_valid) init_writes++;
        if (reg_write) n_wb++;
        if (pc_write_cond) n_cond++;
        if (pc_write && !mark_now) n_pcw++;
        if (mem_wr) n_mem++;
        if (epc_load) n_epc++;
        if (mark_now) begin
            if (cur_valid) begin
                n_done++;
                hits[B_LEN]++;
                hits[B_WB]++;
                if (exp_cond == 1 || exp_kind == K_JUMP || exp_kind == K_JR) hits[B_XFER]++;
                if (exp_mem == 1) hits[B_STORE]++;
                if (exp_epc == 1) hits[B_EXC]++;
            end else begin
                hits[B_RESET]++;
            end
            load_pend = 1'b1;  // New op one cycle after the marker
        end
        mark_q = mark_now;
    endtask

    task automatic print_summary();
        int total_hits;
        int total_fail;
        total_hits = 0;
        total_fail = 0;
        for (int b = 0; b < N_BEH; b++) begin
            if (hits[b] == 0) begin
                $display("%s: never exercised by the stimulus", bname[b]);
                fails[b]++;
            end
            $display("%s: %0d checked, %0d failed", bname[b], hits[b], fails[b]);
            total_hits += hits[b];
            total_fail += fails[b];
        end
        $display("%0d instructions, %0d checks, %0d errors", n_done, total_hits, total_fail);
        if (total_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
    endtask

    initial begin
        void'($urandom(32'h6c694f61));
        clk    = 1'b0;
        arst_n = 1'b1;
        op     = `CU_OP_LW;
        funct  = 6'h00;
        fill_table();
        #1;
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (n_done < N_INSTR) begin
            @(posedge clk);
            #1;
            step_cycle();
        end
        @(posedge clk);  // Last marker checks fire here
        #1;
        print_summary();
        $finish;
    end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> enables == '0)
        else report_error(B_RESET, 0, 32'($sampled(enables)));
    reset_sel: assert property (@(posedge clk) !arst_n |-> selects == '0)
        else report_error(B_RESET, 0, 32'($sampled(selects)));
    reset_sp: assert property (@(posedge clk) disable iff (!arst_n)
        reg_write && !cur_valid |-> init_sel == {`CU_DST_SP, `CU_WB_SP_INIT})
        else report_error(B_RESET, {`CU_DST_SP, `CU_WB_SP_INIT}, 32'($sampled(init_sel)));
    reset_once: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && !cur_valid |-> init_writes == 1)
        else report_error(B_RESET, 1, init_writes);
    length_ok: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && cur_valid |-> gap == exp_len)
        else report_error(B_LEN, exp_len, gap);
    wb_sel: assert property (@(posedge clk) disable iff (!arst_n)
        reg_write && cur_valid |-> wb_act == wb_exp)
        else report_error(B_WB, 32'($sampled(wb_exp)), 32'($sampled(wb_act)));
    wb_count: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && cur_valid |-> n_wb == exp_wb)
        else report_error(B_WB, exp_wb, n_wb);
    br_sel: assert property (@(posedge clk) disable iff (!arst_n)
        pc_write_cond |-> exp_kind == K_BR && br_act == {`CU_PCSRC_ALUOUT, exp_arg})
        else report_error(B_XFER, {`CU_PCSRC_ALUOUT, exp_arg}, 32'($sampled(br_act)));
    pcw_sel: assert property (@(posedge clk) disable iff (!arst_n)
        pc_write && !mark_now |-> sel_pc_source == jump_src(exp_kind))
        else report_error(B_XFER, 32'(jump_src(exp_kind)), 32'($sampled(sel_pc_source)));
    jr_pass: assert property (@(posedge clk) disable iff (!arst_n)
        pc_write && !mark_now && exp_kind == K_JR |-> sel_alu_op == `CU_ALU_PASS_A)
        else report_error(B_XFER, `CU_ALU_PASS_A, 32'($sampled(sel_alu_op)));
    cond_count: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && cur_valid |-> n_cond == exp_cond)
        else report_error(B_XFER, exp_cond, n_cond);
    pcw_count: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && cur_valid |-> n_pcw == exp_pcw)
        else report_error(B_XFER, exp_pcw, n_pcw);
    store_sel: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr |-> exp_kind == K_STORE && st_act == {`CU_IORD_ALUOUT, exp_arg})
        else report_error(B_STORE, {`CU_IORD_ALUOUT, exp_arg}, 32'($sampled(st_act)));
    store_count: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && cur_valid |-> n_mem == exp_mem)
        else report_error(B_STORE, exp_mem, n_mem);
    epc_order: assert property (@(posedge clk) disable iff (!arst_n)
        pc_write && sel_pc_source == `CU_PCSRC_EXC |-> n_epc == 1)
        else report_error(B_EXC, 1, n_epc);
    epc_count: assert property (@(posedge clk) disable iff (!arst_n)
        mark_now && cur_valid |-> n_epc == exp_epc)
        else report_error(B_EXC, exp_epc, n_epc);

endmodule

/* rtl/control_unit.sv */
`include "cu_macros.svh"

module control_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CU_OP_W-1:0]     op,
    input  logic [`CU_OP_W-1:0]     funct,
    output logic                    ab_load,
    output logic                    ir_load,
    output logic                    pc_write,
    output logic                    pc_write_cond,
    output logic                    reg_write,
    output logic                    mem_wr,
    output logic                    epc_load,
    output logic                    alu_out_load,
    output logic                    mdr_load,
    output logic                    sel_reg_read,
    output logic                    sel_alu_src_a,
    output logic [`CU_SRCB_W-1:0]   sel_alu_src_b,
    output logic [`CU_BR_W-1:0]     sel_branch_op,
    output logic [`CU_SIZE_W-1:0]   ls_size,
    output logic [`CU_SIZE_W-1:0]   ss_size,
    output logic [`CU_ALU_W-1:0]    sel_alu_op,
    output logic [`CU_PCSRC_W-1:0]  sel_pc_source,
    output logic [`CU_IORD_W-1:0]   sel_iord,
    output logic [`CU_DST_W-1:0]    sel_reg_dst,
    output logic [`CU_WB_W-1:0]     sel_mem_to_reg
);

    cu_pkg::instr_class_t         instr_class;
    cu_pkg::state_t               state;
    logic [`CU_ALU_W-1:0]         alu_op;
    logic [`CU_BR_W-1:0]          branch_op;
    logic [`CU_SIZE_W-1:0]        mem_size;

    instr_decoder u_decoder (
        .op          (op),
        .funct       (funct),
        .instr_class (instr_class),
        .alu_op      (alu_op),
        .branch_op   (branch_op),
        .mem_size    (mem_size)
    );

    control_sequencer u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_class (instr_class),
        .state       (state)
    );

    control_outputs u_outputs (
        .clk            (clk),
        .arst_n         (arst_n),
        .state          (state),
        .alu_op         (alu_op),
        .branch_op      (branch_op),
        .mem_size       (mem_size),
        .ab_load        (ab_load),
        .ir_load        (ir_load),
        .pc_write       (pc_write),
        .pc_write_cond  (pc_write_cond),
        .reg_write      (reg_write),
        .mem_wr         (mem_wr),
        .epc_load       (epc_load),
        .alu_out_load   (alu_out_load),
        .mdr_load       (mdr_load),
        .sel_reg_read   (sel_reg_read),
        .sel_alu_src_a  (sel_alu_src_a),
        .sel_alu_src_b  (sel_alu_src_b),
        .sel_branch_op  (sel_branch_op),
        .ls_size        (ls_size),
        .ss_size        (ss_size),
        .sel_alu_op     (sel_alu_op),
        .sel_pc_source  (sel_pc_source),
        .sel_iord       (sel_iord),
        .sel_reg_dst    (sel_reg_dst),
        .sel_mem_to_reg (sel_mem_to_reg)
    );

endmodule

/* rtl/control_outputs.sv */
`include "cu_macros.svh"

module control_outputs (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cu_pkg::state_t          state,
    input  logic [`CU_ALU_W-1:0]    alu_op,
    input  logic [`CU_BR_W-1:0]     branch_op,
    input  logic [`CU_SIZE_W-1:0]   mem_size,
    output logic                    ab_load,
    output logic                    ir_load,
    output logic                    pc_write,
    output logic                    pc_write_cond,
    output logic                    reg_write,
    output logic                    mem_wr,
    output logic                    epc_load,
    output logic                    alu_out_load,
    output logic                    mdr_load,
    output logic                    sel_reg_read,
    output logic                    sel_alu_src_a,
    output logic [`CU_SRCB_W-1:0]   sel_alu_src_b,
    output logic [`CU_BR_W-1:0]     sel_branch_op,
    output logic [`CU_SIZE_W-1:0]   ls_size,
    output logic [`CU_SIZE_W-1:0]   ss_size,
    output logic [`CU_ALU_W-1:0]    sel_alu_op,
    output logic [`CU_PCSRC_W-1:0]  sel_pc_source,
    output logic [`CU_IORD_W-1:0]   sel_iord,
    output logic [`CU_DST_W-1:0]    sel_reg_dst,
    output logic [`CU_WB_W-1:0]     sel_mem_to_reg
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ab_load        <= 1'b0;
            ir_load        <= 1'b0;
            pc_write       <= 1'b0;
            pc_write_cond  <= 1'b0;
            reg_write      <= 1'b0;
            mem_wr         <= 1'b0;
            epc_load       <= 1'b0;
            alu_out_load   <= 1'b0;
            mdr_load       <= 1'b0;
            sel_reg_read   <= 1'b0;
            sel_alu_src_a  <= 1'b0;
            sel_alu_src_b  <= '0;
            sel_branch_op  <= '0;
            ls_size        <= '0;
            ss_size        <= '0;
            sel_alu_op     <= '0;
            sel_pc_source  <= '0;
            sel_iord       <= '0;
            sel_reg_dst    <= '0;
            sel_mem_to_reg <= '0;
        end else begin
            ab_load       <= 1'b0;
            ir_load       <= 1'b0;
            pc_write      <= 1'b0;
            pc_write_cond <= 1'b0;
            reg_write     <= 1'b0;
            mem_wr        <= 1'b0;
            epc_load      <= 1'b0;
            alu_out_load  <= 1'b0;
            mdr_load      <= 1'b0;
            case (state)
                cu_pkg::st_init: begin
                    // Stack pointer to its start value
                    sel_reg_dst    <= `CU_DST_SP;
                    sel_mem_to_reg <= `CU_WB_SP_INIT;
                    reg_write      <= 1'b1;
                end
                cu_pkg::fetch1: sel_iord <= `CU_IORD_PC;
                cu_pkg::fetch2: begin
                    sel_alu_src_a <= 1'b0;
                    sel_alu_src_b <= `CU_SRCB_FOUR;
                    sel_alu_op    <= `CU_ALU_ADD;
                    sel_pc_source <= `CU_PCSRC_ALU;
                    pc_write      <= 1'b1;  // PC + 4
                end
                cu_pkg::decode1: begin
                    sel_reg_read <= 1'b0;
                    ir_load      <= 1'b1;
                end
                cu_pkg::decode2: ab_load <= 1'b1;
                cu_pkg::decode3: begin
                    // Branch target computed ahead of the class decision
                    sel_alu_src_a <= 1'b0;
                    sel_alu_src_b <= `CU_SRCB_BROFF;
                    sel_alu_op    <= `CU_ALU_ADD;
                    alu_out_load  <= 1'b1;
                end
                cu_pkg::alu_r, cu_pkg::alu_i: begin
                    sel_alu_src_a <= 1'b1;
                    sel_alu_src_b <= (state == cu_pkg::alu_r) ? `CU_SRCB_B : `CU_SRCB_IMM;
                    sel_alu_op    <= alu_op;
                    alu_out_load  <= 1'b1;
                end
                cu_pkg::save_rd, cu_pkg::save_rt: begin
                    sel_reg_dst    <= (state == cu_pkg::save_rd) ? `CU_DST_RD : `CU_DST_RT;
                    sel_mem_to_reg <= `CU_WB_ALUOUT;
                    reg_write      <= 1'b1;
                end
                cu_pkg::slt: begin
                    sel_alu_src_a  <= 1'b1;
                    sel_alu_src_b  <= (alu_op == `CU_ALU_CMP) ? `CU_SRCB_B : `CU_SRCB_IMM;
                    sel_alu_op     <= `CU_ALU_CMP;
                    sel_reg_dst    <= `CU_DST_RD;
                    sel_mem_to_reg <= `CU_WB_SLT;
                    reg_write      <= 1'b1;
                end
                cu_pkg::lui: begin
                    sel_reg_dst    <= `CU_DST_RT;
                    sel_mem_to_reg <= `CU_WB_LUI;
                    reg_write      <= 1'b1;
                end
                cu_pkg::branch: begin
                    sel_alu_src_a <= 1'b1;
                    sel_alu_src_b <= `CU_SRCB_B;
                    sel_alu_op    <= `CU_ALU_CMP;
                    sel_branch_op <= branch_op;
                    sel_pc_source <= `CU_PCSRC_ALUOUT;
                    pc_write_cond <= 1'b1;
                end
                cu_pkg::jump: begin
                    sel_pc_source <= `CU_PCSRC_JUMP;
                    pc_write      <= 1'b1;
                end
                cu_pkg::jal1: begin
                    sel_alu_src_a <= 1'b0;  // Return address is the current PC
                    sel_alu_op    <= `CU_ALU_PASS_A;
                    alu_out_load  <= 1'b1;
                end
                cu_pkg::jal2: begin
                    sel_reg_dst    <= `CU_DST_RA;
                    sel_mem_to_reg <= `CU_WB_ALUOUT;
                    reg_write      <= 1'b1;
                end
                cu_pkg::jr1: begin
                    sel_alu_src_a <= 1'b1;
                    sel_alu_op    <= `CU_ALU_PASS_A;
                end
                cu_pkg::jr2: begin
                    sel_pc_source <= `CU_PCSRC_ALU;
                    pc_write      <= 1'b1;
                end
                cu_pkg::ls_addr: begin
                    sel_alu_src_a <= 1'b1;
                    sel_alu_src_b <= `CU_SRCB_IMM;
                    sel_alu_op    <= `CU_ALU_ADD;
                    alu_out_load  <= 1'b1;
                end
                cu_pkg::ls_read:  sel_iord <= `CU_IORD_ALUOUT;
                cu_pkg::mdr_load: mdr_load <= 1'b1;
                cu_pkg::load_wb: begin
                    ls_size        <= mem_size;
                    sel_reg_dst    <= `CU_DST_RT;
                    sel_mem_to_reg <= `CU_WB_MDR;
                    reg_write      <= 1'b1;
                end
                cu_pkg::store_wr: begin
                    // Merge into the word read back through the MDR
                    ss_size <= mem_size;
                    mem_wr  <= 1'b1;
                end
                cu_pkg::exc_epc: begin
                    sel_alu_src_a <= 1'b0;
                    sel_alu_src_b <= `CU_SRCB_FOUR;
                    sel_alu_op    <= `CU_ALU_SUB;  // Back to the faulting instruction
                    epc_load      <= 1'b1;
                end
                cu_pkg::exc_read: sel_iord <= `CU_IORD_EXC;
                cu_pkg::exc_vec: begin
                    ls_size       <= `CU_SIZE_BYTE;  // Vector is a single byte
                    sel_pc_source <= `CU_PCSRC_EXC;
                    mdr_load      <= 1'b1;
                end
                cu_pkg::exc_pc: pc_write <= 1'b1;
                default: ;
            endcase
        end
    end

    pc_write_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(pc_write && pc_write_cond))
        else $error("pc_write and pc_write_cond high together");

    store_addr: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr |-> sel_iord == `CU_IORD_ALUOUT)
        else $error("mem_wr without the ALU out address");

    wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_write && mem_wr))
        else $error("reg_write and mem_wr high together");

endmodule

/* rtl/control_sequencer.sv */
module control_sequencer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cu_pkg::instr_class_t instr_class,
    output cu_pkg::state_t       state
);

    cu_pkg::state_t next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cu_pkg::st_init;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // Last state of every sequence falls back to fetch
        next_state = cu_pkg::fetch1;
        case (state)
            cu_pkg::fetch1:  next_state = cu_pkg::fetch2;
            cu_pkg::fetch2:  next_state = cu_pkg::decode1;
            cu_pkg::decode1: next_state = cu_pkg::decode2;
            cu_pkg::decode2: next_state = cu_pkg::decode3;
            cu_pkg::decode3: begin
                case (instr_class)
                    cu_pkg::cls_alu_r:  next_state = cu_pkg::alu_r;
                    cu_pkg::cls_alu_i:  next_state = cu_pkg::alu_i;
                    cu_pkg::cls_slt,
                    cu_pkg::cls_slti:   next_state = cu_pkg::slt;
                    cu_pkg::cls_lui:    next_state = cu_pkg::lui;
                    cu_pkg::cls_branch: next_state = cu_pkg::branch;
                    cu_pkg::cls_j:      next_state = cu_pkg::jump;
                    cu_pkg::cls_jal:    next_state = cu_pkg::jal1;
                    cu_pkg::cls_jr:     next_state = cu_pkg::jr1;
                    cu_pkg::cls_load,
                    cu_pkg::cls_store:  next_state = cu_pkg::ls_addr;
                    default:            next_state = cu_pkg::exc_epc;
                endcase
            end
            cu_pkg::alu_r:   next_state = cu_pkg::save_rd;
            cu_pkg::alu_i:   next_state = cu_pkg::save_rt;
            cu_pkg::jal1:    next_state = cu_pkg::jal2;
            cu_pkg::jal2:    next_state = cu_pkg::jump;  // Link then share the jump state
            cu_pkg::jr1:     next_state = cu_pkg::jr2;
            cu_pkg::ls_addr: next_state = cu_pkg::ls_read;
            cu_pkg::ls_read: next_state = cu_pkg::ls_wait;
            cu_pkg::ls_wait: next_state = cu_pkg::mdr_load;
            cu_pkg::mdr_load: begin
                if (instr_class == cu_pkg::cls_store) begin
                    next_state = cu_pkg::store_wr;
                end else begin
                    next_state = cu_pkg::load_wb;
                end
            end
            cu_pkg::store_wr: next_state = cu_pkg::store_wait;
            cu_pkg::exc_epc:  next_state = cu_pkg::exc_read;
            cu_pkg::exc_read: next_state = cu_pkg::exc_wait;
            cu_pkg::exc_wait: next_state = cu_pkg::exc_vec;
            cu_pkg::exc_vec:  next_state = cu_pkg::exc_pc;
            default:          next_state = cu_pkg::fetch1;
        endcase
    end

    // Fetch is entered only from the end of a sequence
    fetch_step: assert property (@(posedge clk) disable iff (!arst_n)
        state == cu_pkg::fetch1 |-> $past(state) inside {cu_pkg::st_init, cu_pkg::save_rd,
            cu_pkg::save_rt, cu_pkg::slt, cu_pkg::lui, cu_pkg::branch, cu_pkg::jump,
            cu_pkg::jr2, cu_pkg::load_wb, cu_pkg::store_wait, cu_pkg::exc_pc})
        else $error("fetch1 reached from the middle of an instruction sequence");

endmodule

/* rtl/instr_decoder.sv */
`include "cu_macros.svh"

module instr_decoder (
    input  logic [`CU_OP_W-1:0]   op,
    input  logic [`CU_OP_W-1:0]   funct,
    output cu_pkg::instr_class_t  instr_class,
    output logic [`CU_ALU_W-1:0]  alu_op,
    output logic [`CU_BR_W-1:0]   branch_op,
    output logic [`CU_SIZE_W-1:0] mem_size
);

    always_comb begin
        instr_class = cu_pkg::cls_invalid;
        alu_op      = `CU_ALU_ADD;
        branch_op   = `CU_BR_EQ;
        mem_size    = `CU_SIZE_WORD;
        case (op)
            `CU_OP_RTYPE: begin
                case (funct)
                    `CU_FN_ADD: instr_class = cu_pkg::cls_alu_r;
                    `CU_FN_SUB: begin
                        instr_class = cu_pkg::cls_alu_r;
                        alu_op      = `CU_ALU_SUB;
                    end
                    `CU_FN_AND: begin
                        instr_class = cu_pkg::cls_alu_r;
                        alu_op      = `CU_ALU_AND;
                    end
                    `CU_FN_SLT: begin
                        instr_class = cu_pkg::cls_slt;
                        alu_op      = `CU_ALU_CMP;  // Register compare, slti keeps ADD
                    end
                    `CU_FN_JR:  instr_class = cu_pkg::cls_jr;
                    default:    instr_class = cu_pkg::cls_invalid;
                endcase
            end
            `CU_OP_ADDI, `CU_OP_ADDIU: instr_class = cu_pkg::cls_alu_i;
            `CU_OP_SLTI: instr_class = cu_pkg::cls_slti;
            `CU_OP_LUI:  instr_class = cu_pkg::cls_lui;
            `CU_OP_BEQ:  instr_class = cu_pkg::cls_branch;
            `CU_OP_BNE: begin
                instr_class = cu_pkg::cls_branch;
                branch_op   = `CU_BR_NE;
            end
            `CU_OP_BGT: begin
                instr_class = cu_pkg::cls_branch;
                branch_op   = `CU_BR_GT;
            end
            `CU_OP_BLE: begin
                instr_class = cu_pkg::cls_branch;
                branch_op   = `CU_BR_LE;
            end
            `CU_OP_J:    instr_class = cu_pkg::cls_j;
            `CU_OP_JAL:  instr_class = cu_pkg::cls_jal;
            `CU_OP_LW:   instr_class = cu_pkg::cls_load;
            `CU_OP_LH: begin
                instr_class = cu_pkg::cls_load;
                mem_size    = `CU_SIZE_HALF;
            end
            `CU_OP_LB: begin
                instr_class = cu_pkg::cls_load;
                mem_size    = `CU_SIZE_BYTE;
            end
            `CU_OP_SW:   instr_class = cu_pkg::cls_store;
            `CU_OP_SH: begin
                instr_class = cu_pkg::cls_store;
                mem_size    = `CU_SIZE_HALF;
            end
            `CU_OP_SB: begin
                instr_class = cu_pkg::cls_store;
                mem_size    = `CU_SIZE_BYTE;
            end
            default:     instr_class = cu_pkg::cls_invalid;
        endcase
    end

endmodule

/* rtl/cu_pkg.sv */
package cu_pkg;

    typedef enum logic [5:0] {
        st_init,
        fetch1, fetch2, decode1, decode2, decode3,
        alu_r, alu_i, save_rd, save_rt, slt,
        lui,
        branch,
        jump, jal1, jal2, jr1, jr2,
        // Shared load/store path up to the MDR
        ls_addr, ls_read, ls_wait, mdr_load, load_wb, store_wr, store_wait,
        // Invalid opcode handling
        exc_epc, exc_read, exc_wait, exc_vec, exc_pc
    } state_t;

    typedef enum logic [3:0] {
        cls_alu_r,
        cls_slt,
        cls_alu_i,
        cls_slti,
        cls_lui,
        cls_branch,
        cls_j,
        cls_jal,
        cls_jr,
        cls_load,
        cls_store,
        cls_invalid
    } instr_class_t;

endpackage

/* rtl/cu_macros.svh */
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

`define CU_OP_W         6

// Opcodes
`define CU_OP_RTYPE     6'h00
`define CU_OP_J         6'h02
`define CU_OP_JAL       6'h03
`define CU_OP_BEQ       6'h04
`define CU_OP_BNE       6'h05
`define CU_OP_BLE       6'h06
`define CU_OP_BGT       6'h07
`define CU_OP_ADDI      6'h08
`define CU_OP_ADDIU     6'h09
`define CU_OP_SLTI      6'h0a
`define CU_OP_LUI       6'h0f
`define CU_OP_LB        6'h20
`define CU_OP_LH        6'h21
`define CU_OP_LW        6'h23
`define CU_OP_SB        6'h28
`define CU_OP_SH        6'h29
`define CU_OP_SW        6'h2b

// R-type function field
`define CU_FN_JR        6'h08
`define CU_FN_ADD       6'h20
`define CU_FN_SUB       6'h22
`define CU_FN_AND       6'h24
`define CU_FN_SLT       6'h2a

`define CU_ALU_W        3
`define CU_ALU_PASS_A   3'd0
`define CU_ALU_ADD      3'd1
`define CU_ALU_SUB      3'd2
`define CU_ALU_AND      3'd3
`define CU_ALU_CMP      3'd7

`define CU_SRCB_W       2
`define CU_SRCB_B       2'd0
`define CU_SRCB_FOUR    2'd1
`define CU_SRCB_IMM     2'd2
`define CU_SRCB_BROFF   2'd3  // Sign-extended offset shifted by two

`define CU_PCSRC_W      3
`define CU_PCSRC_ALU    3'd0
`define CU_PCSRC_ALUOUT 3'd1
`define CU_PCSRC_JUMP   3'd2
`define CU_PCSRC_EXC    3'd6

`define CU_IORD_W       3
`define CU_IORD_PC      3'd0
`define CU_IORD_ALUOUT  3'd1
`define CU_IORD_EXC     3'd2

`define CU_DST_W        3
`define CU_DST_RT       3'd0
`define CU_DST_SP       3'd1
`define CU_DST_RA       3'd2
`define CU_DST_RD       3'd3

`define CU_WB_W         4
`define CU_WB_ALUOUT    4'd0
`define CU_WB_MDR       4'd1
`define CU_WB_SP_INIT   4'd5
`define CU_WB_LUI       4'd6
`define CU_WB_SLT       4'd8

`define CU_SIZE_W       2
`define CU_SIZE_WORD    2'd0
`define CU_SIZE_HALF    2'd2
`define CU_SIZE_BYTE    2'd3

`define CU_BR_W         2
`define CU_BR_EQ        2'd0
`define CU_BR_NE        2'd1
`define CU_BR_GT        2'd2
`define CU_BR_LE        2'd3

`endif
